/* filelist.f */
+incdir+bench
source/mbox_pkg.sv
source/pending_size.sv
source/dp_ram.sv
source/fifo_queue.sv
source/mbox_regs.sv
source/mbox_top.sv
bench/mbox_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := mbox_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail, the simulator status alone is not trusted
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/mbox_tb_checks.svh */
`ifndef MBOX_TB_CHECKS_SVH
`define MBOX_TB_CHECKS_SVH

// Galois LFSR step with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

// Sets every APB request field for the coming cycle
task automatic drive_apb(
    input logic              sel,
    input logic              enable,
    input logic              write,
    input logic [ADDR_W-1:0] addr,
    input logic [DATA_W-1:0] wdata
);
    apb_req = '{paddr: addr, psel: sel, penable: enable, pwrite: write, pwdata: wdata};
endtask

task automatic report_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first mismatch");
endtask

task automatic check_rsp(input apb_rsp_t actual, input apb_rsp_t expected, input string what);
    if (actual !== expected) begin
        report_error($sformatf("%s prdata %h pready %b pslverr %b, expected %h %b %b",
            what, actual.prdata, actual.pready, actual.pslverr,
            expected.prdata, expected.pready, expected.pslverr));
    end
endtask

// Data is only compared while the word is valid
task automatic check_stream(input stream_t actual, input stream_t expected, input string what);
    if (actual.valid !== expected.valid
        || (expected.valid && actual.data !== expected.data)) begin
        report_error($sformatf("%s valid %b data %h, expected valid %b data %h",
            what, actual.valid, actual.data, expected.valid, expected.data));
    end
endtask

task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
        report_error($sformatf("%s is %b, expected %b", what, actual, expected));
    end
endtask

`endif

/* bench/mbox_tb.sv */
`timescale 1ns/1ns

module mbox_tb;

    import mbox_pkg::*;

    localparam int DEPTH     = 8;
    localparam int ALM_FULL  = 6;
    localparam int ALM_EMPTY = 1;
    localparam int NSTEPS    = 48;

    localparam logic [1:0] OP_IDLE  = 2'd0;
    localparam logic [1:0] OP_WRITE = 2'd1;
    localparam logic [1:0] OP_READ  = 2'd2;

    localparam logic [ADDR_W-1:0] REG_UNMAPPED = 4'hc;

    // Each table row ignores exp_data when from_model is set
    typedef struct packed {
        logic [1:0]        op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              tx_ready;
        logic              rx_valid;
        logic              exp_err;
        logic              from_model;
        logic [DATA_W-1:0] exp_data;
    } step_t;

    logic     clk;
    logic     reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    stream_t  tx_out;
    logic     tx_ready;
    stream_t  rx_in;
    logic     rx_ready;
    logic     irq;

    // Reference queues and the CTRL enable as the DUT should hold them
    logic [DATA_W-1:0] tx_model [$];
    logic [DATA_W-1:0] rx_model [$];
    logic              ctrl_model;
    logic [31:0]       lfsr_state;

    step_t steps [NSTEPS] = '{
        '{OP_READ,  REG_STATUS,   32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_CTRL,     32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_WRITE, REG_DATA,     32'h1111_1111, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_WRITE, REG_DATA,     32'h2222_2222, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_WRITE, REG_DATA,     32'h3333_3333, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_IDLE,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0},
        // Fill the transmit queue to the brim while its stream is stalled
        '{OP_WRITE, REG_DATA,     32'ha000_0000, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_WRITE, REG_DATA,     32'ha000_0001, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_WRITE, REG_DATA,     32'ha000_0002, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_WRITE, REG_DATA,     32'ha000_0003, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_WRITE, REG_DATA,     32'ha000_0004, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  REG_STATUS,   32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_WRITE, REG_DATA,     32'ha000_0005, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  REG_STATUS,   32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_WRITE, REG_DATA,     32'ha000_0006, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_WRITE, REG_DATA,     32'ha000_0007, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_WRITE, REG_DATA,     32'h0bad_0bad, 1'b0, 1'b0, 1'b1, 1'b0, 32'h0},
        '{OP_READ,  REG_STATUS,   32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_IDLE,  REG_DATA,     32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_IDLE,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0},
        // The access cycle here pushes and pops the transmit queue together
        '{OP_WRITE, REG_DATA,     32'hc000_0000, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  REG_STATUS,   32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_STATUS,   32'h0000_0000, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_STATUS,   32'h0000_0000, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_STATUS,   32'h0000_0000, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_STATUS,   32'h0000_0000, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_STATUS,   32'h0000_0000, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0},
        '{OP_WRITE, REG_CTRL,     32'h0000_0001, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  REG_CTRL,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0},
        '{OP_IDLE,  REG_DATA,     32'h0000_0000, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  REG_STATUS,   32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0},
        '{OP_WRITE, REG_STATUS,   32'h0000_00ff, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0},
        '{OP_READ,  REG_UNMAPPED, 32'h0000_0000, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0},
        '{OP_WRITE, REG_UNMAPPED, 32'h1234_5678, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0},
        '{OP_WRITE, REG_CTRL,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0},
        '{OP_IDLE,  REG_DATA,     32'h0000_0000, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  REG_DATA,     32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0}
    };

    `include "mbox_tb_checks.svh"

    mbox_top #(
        .DEPTH     (DEPTH),
        .ALM_FULL  (ALM_FULL),
        .ALM_EMPTY (ALM_EMPTY)
    ) dut_i (
        .clk      (clk),
        .reset    (reset),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .tx_out   (tx_out),
        .tx_ready (tx_ready),
        .rx_in    (rx_in),
        .rx_ready (rx_ready),
        .irq      (irq)
    );

    function automatic fifo_status_t queue_status(input int count);
        fifo_status_t st;
        st.empty     = (count == 0);
        st.alm_empty = (count <= ALM_EMPTY);
        st.full      = (count == DEPTH);
        st.alm_full  = (count >= ALM_FULL);
        st.size      = SIZE_W'(count);
        return st;
    endfunction

    // Read data the register map should return for the model state
    function automatic logic [DATA_W-1:0] model_rdata(input logic [ADDR_W-1:0] addr);
        fifo_status_t tx_s;
        fifo_status_t rx_s;
        tx_s = queue_status(tx_model.size());
        rx_s = queue_status(rx_model.size());
        if (addr == REG_DATA) begin
            return (rx_model.size() != 0) ? rx_model[0] : '0;
        end
        if (addr == REG_STATUS) begin
            return {8'h00, rx_s.size, tx_s.size,
                    rx_s.alm_full, rx_s.full, rx_s.alm_empty, rx_s.empty,
                    tx_s.alm_full, tx_s.full, tx_s.alm_empty, tx_s.empty};
        end
        return '0;
    endfunction

    task automatic draw_word(output logic [DATA_W-1:0] word);
        word = '0;
        for (int b = 0; b < DATA_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            word = {word[DATA_W-2:0], lfsr_state[0]};
        end
    endtask

    // One clock cycle of a step checked ahead of the rising edge
    task automatic run_cycle(input step_t st, input logic access_phase);
        apb_rsp_t          exp_rsp;
        stream_t           exp_tx;
        logic [DATA_W-1:0] rx_word;
        logic              active;
        logic              done;
        logic              rx_push;
        @(negedge clk);
        active = (st.op != OP_IDLE);
        done   = active && access_phase;
        drive_apb(active, done, st.op == OP_WRITE, st.addr, st.wdata);
        tx_ready = st.tx_ready;
        rx_word  = '0;
        if (st.rx_valid) begin
            draw_word(rx_word);
        end
        rx_in = '{valid: st.rx_valid, data: rx_word};
        #10;
        exp_tx = '{valid: (tx_model.size() != 0),
                   data: (tx_model.size() != 0) ? tx_model[0] : '0};
        check_stream(tx_out, exp_tx, "tx_out");
        check_bit(rx_ready, rx_model.size() < DEPTH, "rx_ready");
        check_bit(irq, ctrl_model && rx_model.size() != 0, "irq");
        exp_rsp = '{prdata: '0, pready: 1'b1, pslverr: done && st.exp_err};
        if (done && st.op == OP_READ) begin
            exp_rsp.prdata = st.from_model ? model_rdata(st.addr) : st.exp_data;
        end
        check_rsp(apb_rsp, exp_rsp, "APB response");

        // Pops go first so a push in the same cycle lands behind the old head
        rx_push = st.rx_valid && rx_model.size() < DEPTH;
        if (st.tx_ready && tx_model.size() != 0) begin
            void'(tx_model.pop_front());
        end
        if (done && !st.exp_err) begin
            if (st.op == OP_WRITE && st.addr == REG_DATA) begin
                tx_model.push_back(st.wdata);
            end
            if (st.op == OP_READ && st.addr == REG_DATA) begin
                void'(rx_model.pop_front());
            end
            if (st.op == OP_WRITE && st.addr == REG_CTRL) begin
                ctrl_model = st.wdata[0];
            end
        end
        if (rx_push) begin
            rx_model.push_back(rx_word);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        repeat ((NSTEPS + 16) * 4) @(posedge clk);
        $display("Timeout: the step table did not finish in %0d cycles", (NSTEPS + 16) * 4);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        reset      = 1'b1;
        tx_ready   = 1'b0;
        rx_in      = '0;
        ctrl_model = 1'b0;
        lfsr_state = 32'hc041;
        drive_apb(1'b0, 1'b0, 1'b0, '0, '0);
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (steps[i]) begin
            run_cycle(steps[i], 1'b0);
            if (steps[i].op != OP_IDLE) begin
                run_cycle(steps[i], 1'b1);
            end
        end
        @(negedge clk);
        drive_apb(1'b0, 1'b0, 1'b0, '0, '0);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* source/mbox_top.sv */
`timescale 1ns/1ns

module mbox_top #(
    parameter int DEPTH     = 8,
    parameter int ALM_FULL  = 6,
    parameter int ALM_EMPTY = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  mbox_pkg::apb_req_t apb_req,
    output mbox_pkg::apb_rsp_t apb_rsp,
    output mbox_pkg::stream_t  tx_out,
    input  logic               tx_ready,
    input  mbox_pkg::stream_t  rx_in,
    output logic               rx_ready,
    output logic               irq
);

    import mbox_pkg::*;

    fifo_status_t      tx_status;
    fifo_status_t      rx_status;
    logic              tx_push;
    logic              tx_pop;
    logic [DATA_W-1:0] tx_wdata;
    logic              rx_push;
    logic              rx_pop;
    logic [DATA_W-1:0] rx_head;

    mbox_regs mbox_regs_i (
        .clk         (clk),
        .reset       (reset),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .tx_status   (tx_status),
        .rx_status   (rx_status),
        .rx_head     (rx_head),
        .tx_push     (tx_push),
        .tx_wdata    (tx_wdata),
        .rx_pop      (rx_pop),
        .tx_ready    (tx_ready),
        .tx_pop      (tx_pop),
        .rx_in_valid (rx_in.valid),
        .rx_ready    (rx_ready),
        .rx_push     (rx_push),
        .irq         (irq)
    );

    // Transmit queue filled from APB and drained by the outgoing stream
    fifo_queue #(
        .DEPTH     (DEPTH),
        .ALM_FULL  (ALM_FULL),
        .ALM_EMPTY (ALM_EMPTY)
    ) tx_queue_i (
        .clk      (clk),
        .reset    (reset),
        .push     (tx_push),
        .pop      (tx_pop),
        .data_in  (tx_wdata),
        .data_out (tx_out.data),
        .status   (tx_status)
    );

    assign tx_out.valid = !tx_status.empty;

    // Receive queue filled from the incoming stream and drained by DATA reads
    fifo_queue #(
        .DEPTH     (DEPTH),
        .ALM_FULL  (ALM_FULL),
        .ALM_EMPTY (ALM_EMPTY)
    ) rx_queue_i (
        .clk      (clk),
        .reset    (reset),
        .push     (rx_push),
        .pop      (rx_pop),
        .data_in  (rx_in.data),
        .data_out (rx_head),
        .status   (rx_status)
    );

endmodule

/* source/mbox_regs.sv */
`timescale 1ns/1ns

module mbox_regs (
    input  logic                        clk,
    input  logic                        reset,
    input  mbox_pkg::apb_req_t          apb_req,
    output mbox_pkg::apb_rsp_t          apb_rsp,
    input  mbox_pkg::fifo_status_t      tx_status,
    input  mbox_pkg::fifo_status_t      rx_status,
    input  logic [mbox_pkg::DATA_W-1:0] rx_head,
    output logic                        tx_push,
    output logic [mbox_pkg::DATA_W-1:0] tx_wdata,
    output logic                        rx_pop,
    input  logic                        tx_ready,
    output logic                        tx_pop,
    input  logic                        rx_in_valid,
    output logic                        rx_ready,
    output logic                        rx_push,
    output logic                        irq
);

    import mbox_pkg::*;

    localparam int PAD_W = DATA_W - 2 * SIZE_W - 8;

    logic              access;
    logic              wr_access;
    logic              rd_access;
    logic              ctrl_en;
    logic [DATA_W-1:0] status_word;
    logic [DATA_W-1:0] rdata;
    logic              err;

    // No wait states, so every access phase completes in its own cycle
    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;
    assign rd_access = access && !apb_req.pwrite;

    assign status_word = {
        {PAD_W{1'b0}},
        rx_status.size,
        tx_status.size,
        rx_status.alm_full, rx_status.full, rx_status.alm_empty, rx_status.empty,
        tx_status.alm_full, tx_status.full, tx_status.alm_empty, tx_status.empty
    };

    // Queue control is only issued when the queue can take it
    assign tx_push  = wr_access && (apb_req.paddr == REG_DATA) && !tx_status.full;
    assign tx_wdata = apb_req.pwdata;
    assign rx_pop   = rd_access && (apb_req.paddr == REG_DATA) && !rx_status.empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_en <= 1'b0;
        end else if (wr_access && (apb_req.paddr == REG_CTRL)) begin
            ctrl_en <= apb_req.pwdata[0];
        end
    end

    // Read data and error of the addressed register before access masking
    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (apb_req.paddr)
            REG_DATA: begin
                if (apb_req.pwrite) begin
                    err = tx_status.full;
                end else begin
                    err   = rx_status.empty;
                    rdata = rx_status.empty ? '0 : rx_head;
                end
            end
            REG_STATUS: begin
                if (apb_req.pwrite) begin
                    err = 1'b1;
                end else begin
                    rdata = status_word;
                end
            end
            REG_CTRL: begin
                if (!apb_req.pwrite) begin
                    rdata = DATA_W'(ctrl_en);
                end
            end
            default: begin
                err = 1'b1;
            end
        endcase
    end

    assign apb_rsp = '{
        prdata:  rd_access ? rdata : '0,
        pready:  1'b1,
        pslverr: access && err
    };

    // Stream handshakes follow the queue flags directly
    assign tx_pop   = tx_ready && !tx_status.empty;
    assign rx_ready = !rx_status.full;
    assign rx_push  = rx_in_valid && !rx_status.full;

    assign irq = ctrl_en && !rx_status.empty;

    // A pop without a matching push shrinks the queue by exactly one word
    assert property (@(posedge clk) disable iff (reset)
        (rx_pop && !rx_push) |=> (rx_status.size == $past(rx_status.size) - 1'b1))
        else $error("mbox_regs: receive queue size off after DATA read");

    assert property (@(posedge clk) disable iff (reset)
        (tx_pop && !tx_push) |=> (tx_status.size == $past(tx_status.size) - 1'b1))
        else $error("mbox_regs: transmit queue size off after stream transfer");

endmodule

/* source/fifo_queue.sv */
`timescale 1ns/1ns

module fifo_queue #(
    parameter int DEPTH     = 8,
    parameter int ALM_FULL  = 6,
    parameter int ALM_EMPTY = 1
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        push,
    input  logic                        pop,
    input  logic [mbox_pkg::DATA_W-1:0] data_in,
    output logic [mbox_pkg::DATA_W-1:0] data_out,
    output mbox_pkg::fifo_status_t      status
);

    import mbox_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    initial begin
        assert ((DEPTH & (DEPTH - 1)) == 0)
            else $error("fifo_queue: DEPTH must be a power of two");
        assert (ALM_FULL > 0 && ALM_FULL < DEPTH)
            else $error("fifo_queue: ALM_FULL must lie between 0 and DEPTH");
        assert (ALM_EMPTY > 0 && ALM_EMPTY < DEPTH)
            else $error("fifo_queue: ALM_EMPTY must lie between 0 and DEPTH");
        assert (DEPTH < (1 << SIZE_W))
            else $error("fifo_queue: DEPTH does not fit the size field");
    end

    pending_size #(
        .DEPTH     (DEPTH),
        .ALM_FULL  (ALM_FULL),
        .ALM_EMPTY (ALM_EMPTY)
    ) pending_size_i (
        .clk    (clk),
        .reset  (reset),
        .incr   (push),
        .decr   (pop),
        .status (status)
    );

    // Pointers wrap naturally since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    dp_ram #(
        .DEPTH (DEPTH)
    ) dp_ram_i (
        .clk   (clk),
        .write (push),
        .waddr (wr_ptr),
        .wdata (data_in),
        .raddr (rd_ptr),
        .rdata (data_out)
    );

    // An empty or full counter must agree with the pointers having met
    assert property (@(posedge clk) disable iff (reset)
        (status.empty || status.full) |-> (wr_ptr == rd_ptr))
        else $error("fifo_queue: pointers disagree with the occupancy count");

    // Words written into a queue with room are held until popped
    assert property (@(posedge clk) disable iff (reset)
        (push && status.empty && !pop) |=> (data_out == $past(data_in)))
        else $error("fifo_queue: head word lost after push to empty queue");

endmodule

/* source/dp_ram.sv */
`timescale 1ns/1ns

module dp_ram #(
    parameter int DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       write,
    input  logic [$clog2(DEPTH)-1:0]   waddr,
    input  logic [mbox_pkg::DATA_W-1:0] wdata,
    input  logic [$clog2(DEPTH)-1:0]   raddr,
    output logic [mbox_pkg::DATA_W-1:0] rdata
);

    import mbox_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
    end

    // The read side is asynchronous so the head word is visible without a clock
    assign rdata = mem[raddr];

endmodule

/* source/pending_size.sv */
`timescale 1ns/1ns

module pending_size #(
    parameter int DEPTH     = 8,
    parameter int ALM_FULL  = 6,
    parameter int ALM_EMPTY = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  incr,
    input  logic                  decr,
    output mbox_pkg::fifo_status_t status
);

    import mbox_pkg::*;

    logic [SIZE_W-1:0] size_n;

    // A simultaneous increment and decrement leaves the count where it is
    always_comb begin
        size_n = status.size;
        if (incr && !decr) begin
            size_n = status.size + 1'b1;
        end else if (decr && !incr) begin
            size_n = status.size - 1'b1;
        end
    end

    // Flags are derived from the next count so they line up with size
    always_ff @(posedge clk) begin
        if (reset) begin
            status.size      <= '0;
            status.empty     <= 1'b1;
            status.alm_empty <= 1'b1;
            status.full      <= 1'b0;
            status.alm_full  <= 1'b0;
        end else begin
            status.size      <= size_n;
            status.empty     <= (size_n == '0);
            status.alm_empty <= (size_n <= SIZE_W'(ALM_EMPTY));
            status.full      <= (size_n == SIZE_W'(DEPTH));
            status.alm_full  <= (size_n >= SIZE_W'(ALM_FULL));
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (incr && !decr) |-> !status.full)
        else $error("pending_size: increment of a full queue");

    assert property (@(posedge clk) disable iff (reset)
        (decr && !incr) |-> !status.empty)
        else $error("pending_size: decrement of an empty queue");

endmodule

/* source/mbox_pkg.sv */
package mbox_pkg;

    // Word and address widths shared by the bus, the streams and the queues
    localparam int DATA_W = 32;
    localparam int ADDR_W = 4;

    // Fill level width, enough for queues of up to 128 words
    localparam int SIZE_W = 8;

    // Register byte offsets
    localparam logic [ADDR_W-1:0] REG_DATA   = 4'h0;
    localparam logic [ADDR_W-1:0] REG_STATUS = 4'h4;
    localparam logic [ADDR_W-1:0] REG_CTRL   = 4'h8;

    // Signals driven by the APB master
    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    // Signals returned by the mailbox
    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // One word on a valid/ready stream whose ready travels the other way
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } stream_t;

    typedef struct packed {
        logic              empty;
        logic              alm_empty;
        logic              full;
        logic              alm_full;
        logic [SIZE_W-1:0] size;
    } fifo_status_t;

endpackage
